// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_w     = 32;
    localparam int reg_idx_w  = 5;
    localparam int sel_w      = word_w / 8;
    localparam int imm_w      = 16;
    localparam int jtarg_w    = 26;
    localparam int imem_depth = 64;
    localparam int imem_idx_w = $clog2(imem_depth);

    // opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function codes
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_t;

    // same word seen as r-type or i-type
    typedef union packed {
        struct packed {
            logic [5:0]           op;
            logic [reg_idx_w-1:0] rs;
            logic [reg_idx_w-1:0] rt;
            logic [reg_idx_w-1:0] rd;
            logic [4:0]           shamt;
            logic [5:0]           funct;
        } r;
        struct packed {
            logic [5:0]           op;
            logic [reg_idx_w-1:0] rs;
            logic [reg_idx_w-1:0] rt;
            logic [imm_w-1:0]     imm16;
        } i;
    } instr_u;

endpackage

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [reg_idx_w-1:0] rs_idx,
    input  logic [reg_idx_w-1:0] rt_idx,
    output logic [word_w-1:0]    rs_data,
    output logic [word_w-1:0]    rt_data,
    input  logic                 wr_en,
    input  logic [reg_idx_w-1:0] wr_idx,
    input  logic [word_w-1:0]    wr_data
);

    logic [word_w-1:0] regs [2**reg_idx_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < 2**reg_idx_w; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // writeback in the same cycle shows up on the reads
    assign rs_data = (rs_idx == '0) ? '0 :
                     (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 :
                     (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              redirect,
    input  logic [word_w-1:0] redirect_pc,
    output instr_u            instr,
    output logic [word_w-1:0] pc_plus4
);

    logic [word_w-1:0] rom [imem_depth];
    logic [word_w-1:0] pc;
    logic [word_w-1:0] pc_seq;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign pc_seq = pc + word_w'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            instr    <= '0;
            pc_plus4 <= '0;
        end else if (!stall) begin
            pc       <= redirect ? redirect_pc : pc_seq;
            // wrong-path slot becomes an all-zero no-op
            instr    <= flush ? '0 : rom[pc[imem_idx_w+1:2]];
            pc_plus4 <= pc_seq;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  instr_u               instr,
    input  logic [word_w-1:0]    pc_plus4,
    input  logic                 wb_en,
    input  logic [reg_idx_w-1:0] wb_idx,
    input  logic [word_w-1:0]    wb_data,
    input  logic                 bubble,
    input  logic                 freeze,
    output logic                 redirect,
    output logic [word_w-1:0]    redirect_pc,
    output logic [reg_idx_w-1:0] rs_idx,
    output logic [reg_idx_w-1:0] rt_idx,
    output logic [word_w-1:0]    ex_op_a,
    output logic [word_w-1:0]    ex_op_b,
    output logic [word_w-1:0]    ex_store,
    output alu_op_t              ex_alu_op,
    output logic [reg_idx_w-1:0] ex_dest,
    output logic [reg_idx_w-1:0] ex_rs,
    output logic [reg_idx_w-1:0] ex_rt,
    output logic                 ex_mem_read,
    output logic                 ex_mem_write,
    output logic                 ex_reg_write
);

    logic [word_w-1:0]    rs_data;
    logic [word_w-1:0]    rt_data;
    logic [word_w-1:0]    imm_ext;
    logic [word_w-1:0]    br_target;
    logic [word_w-1:0]    j_target;
    alu_op_t              alu_op;
    logic [reg_idx_w-1:0] dest;
    logic                 use_imm;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 is_beq;
    logic                 is_bne;
    logic                 is_j;

    assign rs_idx = instr.r.rs;
    assign rt_idx = instr.r.rt;

    register_file i_regs (
        .clk     (clk),
        .rst     (rst),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wb_en),
        .wr_idx  (wb_idx),
        .wr_data (wb_data)
    );

    assign imm_ext   = {{(word_w-imm_w){instr.i.imm16[imm_w-1]}}, instr.i.imm16};
    assign br_target = pc_plus4 + {imm_ext[word_w-3:0], 2'b00};
    assign j_target  = {pc_plus4[word_w-1:jtarg_w+2], instr[jtarg_w-1:0], 2'b00};

    always_comb begin
        alu_op    = alu_add;
        dest      = '0;
        use_imm   = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (instr.r.op)
            op_rtype: begin
                dest      = instr.r.rd;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (instr.r.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    // includes the all-zero no-op
                    default: reg_write = 1'b0;
                endcase
            end
            op_addiu, op_lw: begin
                dest      = instr.i.rt;
                use_imm   = 1'b1;
                uses_rs   = 1'b1;
                reg_write = 1'b1;
                mem_read  = (instr.i.op == op_lw);
            end
            op_sw: begin
                use_imm   = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                mem_write = 1'b1;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            op_j:    is_j   = 1'b1;
            default: ;
        endcase
    end

    // branch compare sees register file values only
    assign redirect    = is_j | (is_beq & (rs_data == rt_data)) |
                         (is_bne & (rs_data != rt_data));
    assign redirect_pc = is_j ? j_target : br_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_dest      <= '0;
            ex_rs        <= '0;
            ex_rt        <= '0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (!freeze) begin
            ex_dest      <= (bubble || !reg_write) ? '0 : dest;
            ex_rs        <= (bubble || !uses_rs) ? '0 : instr.r.rs;
            ex_rt        <= (bubble || !uses_rt) ? '0 : instr.r.rt;
            ex_mem_read  <= mem_read & ~bubble;
            ex_mem_write <= mem_write & ~bubble;
            ex_reg_write <= reg_write & ~bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_op_a   <= rs_data;
            ex_op_b   <= use_imm ? imm_ext : rt_data;
            ex_store  <= rt_data;
            ex_alu_op <= alu_op;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`default_nettype none
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  logic [reg_idx_w-1:0] id_rs,
    input  logic [reg_idx_w-1:0] id_rt,
    input  logic [reg_idx_w-1:0] ex_rs,
    input  logic [reg_idx_w-1:0] ex_rt,
    input  logic [reg_idx_w-1:0] ex_dest,
    input  logic                 ex_mem_read,
    input  logic                 ex_reg_write,
    input  logic [reg_idx_w-1:0] mem_dest,
    input  logic                 mem_reg_write,
    input  logic [reg_idx_w-1:0] wb_dest,
    input  logic                 wb_reg_write,
    input  logic                 redirect,
    input  logic                 bus_busy,
    output logic                 stall_front,
    output logic                 bubble_ex,
    output logic                 flush_fd,
    output logic                 freeze,
    output fwd_sel_t             fwd_a,
    output fwd_sel_t             fwd_b,
    output fwd_sel_t             fwd_st
);

    logic     load_use;
    fwd_sel_t rt_sel;

    // memory stage is younger, so it wins over writeback
    always_comb begin
        fwd_a = fwd_none;
        if (ex_rs != '0 && mem_reg_write && mem_dest == ex_rs) begin
            fwd_a = fwd_from_mem;
        end else if (ex_rs != '0 && wb_reg_write && wb_dest == ex_rs) begin
            fwd_a = fwd_from_wb;
        end
    end

    always_comb begin
        rt_sel = fwd_none;
        if (ex_rt != '0 && mem_reg_write && mem_dest == ex_rt) begin
            rt_sel = fwd_from_mem;
        end else if (ex_rt != '0 && wb_reg_write && wb_dest == ex_rt) begin
            rt_sel = fwd_from_wb;
        end
    end

    // rt feeds the alu for r-type, the store data for sw
    assign fwd_b  = ex_reg_write ? rt_sel : fwd_none;
    assign fwd_st = ex_reg_write ? fwd_none : rt_sel;

    assign load_use = ex_mem_read && ex_dest != '0 &&
                      (ex_dest == id_rs || ex_dest == id_rt);

    assign freeze      = bus_busy;
    assign stall_front = bus_busy | load_use;
    assign bubble_ex   = load_use & ~bus_busy;
    assign flush_fd    = redirect & ~stall_front;

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [word_w-1:0]    op_a,
    input  logic [word_w-1:0]    op_b,
    input  logic [word_w-1:0]    store,
    input  alu_op_t              alu_op,
    input  logic [reg_idx_w-1:0] dest,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 reg_write,
    input  fwd_sel_t             fwd_a,
    input  fwd_sel_t             fwd_b,
    input  fwd_sel_t             fwd_st,
    input  logic [word_w-1:0]    mem_alu_result,
    input  logic [word_w-1:0]    wb_data,
    input  logic                 freeze,
    output logic [word_w-1:0]    mem_result,
    output logic [word_w-1:0]    mem_store,
    output logic [reg_idx_w-1:0] mem_dest,
    output logic                 mem_mem_read,
    output logic                 mem_mem_write,
    output logic                 mem_reg_write
);

    logic [word_w-1:0] src_a;
    logic [word_w-1:0] src_b;
    logic [word_w-1:0] src_st;
    logic [word_w-1:0] result;

    assign src_a  = (fwd_a == fwd_from_mem) ? mem_alu_result :
                    (fwd_a == fwd_from_wb) ? wb_data : op_a;
    assign src_b  = (fwd_b == fwd_from_mem) ? mem_alu_result :
                    (fwd_b == fwd_from_wb) ? wb_data : op_b;
    assign src_st = (fwd_st == fwd_from_mem) ? mem_alu_result :
                    (fwd_st == fwd_from_wb) ? wb_data : store;

    always_comb begin
        case (alu_op)
            alu_sub: result = src_a - src_b;
            alu_and: result = src_a & src_b;
            alu_or:  result = src_a | src_b;
            alu_slt: result = word_w'($signed(src_a) < $signed(src_b));
            default: result = src_a + src_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_dest      <= '0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_reg_write <= 1'b0;
        end else if (!freeze) begin
            mem_dest      <= dest;
            mem_mem_read  <= mem_read;
            mem_mem_write <= mem_write;
            mem_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem_result <= result;
            mem_store  <= src_st;
        end
    end

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`default_nettype none
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [word_w-1:0]    alu_result,
    input  logic [word_w-1:0]    store_data,
    input  logic [reg_idx_w-1:0] dest,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 reg_write,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [word_w-1:0]    wb_adr,
    output logic [word_w-1:0]    wb_dat_o,
    input  logic [word_w-1:0]    wb_dat_i,
    output logic [sel_w-1:0]     wb_sel,
    input  logic                 wb_ack,
    output logic                 bus_busy,
    output logic                 wb_en,
    output logic [reg_idx_w-1:0] wb_idx,
    output logic [word_w-1:0]    wb_data
);

    logic              access;
    logic              is_load;
    logic [word_w-1:0] alu_q;
    logic [word_w-1:0] load_q;

    // bus fields come straight from the execute/memory register,
    // which holds still while the slave has not acked
    assign access   = mem_read | mem_write;
    assign wb_cyc   = access;
    assign wb_stb   = access;
    assign wb_we    = mem_write;
    assign wb_adr   = alu_result;
    assign wb_dat_o = store_data;
    assign wb_sel   = '1;
    assign bus_busy = access & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_idx  <= '0;
            is_load <= 1'b0;
        end else if (!bus_busy) begin
            wb_en   <= reg_write;
            wb_idx  <= dest;
            is_load <= mem_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!bus_busy) begin
            alu_q <= alu_result;
        end
        // load data taken in the ack cycle
        if (mem_read && wb_ack) begin
            load_q <= wb_dat_i;
        end
    end

    assign wb_data = is_load ? load_q : alu_q;

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [word_w-1:0] wb_adr,
    output logic [word_w-1:0] wb_dat_o,
    input  logic [word_w-1:0] wb_dat_i,
    output logic [sel_w-1:0]  wb_sel,
    input  logic              wb_ack
);

    // fetch/decode
    instr_u               fd_instr;
    logic [word_w-1:0]    fd_pc_plus4;
    logic                 redirect;
    logic [word_w-1:0]    redirect_pc;
    logic [reg_idx_w-1:0] id_rs;
    logic [reg_idx_w-1:0] id_rt;

    // decode/execute
    logic [word_w-1:0]    ex_op_a;
    logic [word_w-1:0]    ex_op_b;
    logic [word_w-1:0]    ex_store;
    alu_op_t              ex_alu_op;
    logic [reg_idx_w-1:0] ex_dest;
    logic [reg_idx_w-1:0] ex_rs;
    logic [reg_idx_w-1:0] ex_rt;
    logic                 ex_mem_read;
    logic                 ex_mem_write;
    logic                 ex_reg_write;

    // execute/memory and writeback
    logic [word_w-1:0]    mem_result;
    logic [word_w-1:0]    mem_store;
    logic [reg_idx_w-1:0] mem_dest;
    logic                 mem_mem_read;
    logic                 mem_mem_write;
    logic                 mem_reg_write;
    logic                 wb_en;
    logic [reg_idx_w-1:0] wb_idx;
    logic [word_w-1:0]    wb_data;

    // hazard control
    logic                 stall_front;
    logic                 bubble_ex;
    logic                 flush_fd;
    logic                 freeze;
    logic                 bus_busy;
    fwd_sel_t             fwd_a;
    fwd_sel_t             fwd_b;
    fwd_sel_t             fwd_st;

    fetch_stage i_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall_front),
        .flush       (flush_fd),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (fd_instr),
        .pc_plus4    (fd_pc_plus4)
    );

    decode_stage i_decode (
        .clk          (clk),
        .rst          (rst),
        .instr        (fd_instr),
        .pc_plus4     (fd_pc_plus4),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .bubble       (bubble_ex),
        .freeze       (freeze),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .rs_idx       (id_rs),
        .rt_idx       (id_rt),
        .ex_op_a      (ex_op_a),
        .ex_op_b      (ex_op_b),
        .ex_store     (ex_store),
        .ex_alu_op    (ex_alu_op),
        .ex_dest      (ex_dest),
        .ex_rs        (ex_rs),
        .ex_rt        (ex_rt),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write),
        .ex_reg_write (ex_reg_write)
    );

    hazard_unit i_hazard (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .ex_dest       (ex_dest),
        .ex_mem_read   (ex_mem_read),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_dest       (wb_idx),
        .wb_reg_write  (wb_en),
        .redirect      (redirect),
        .bus_busy      (bus_busy),
        .stall_front   (stall_front),
        .bubble_ex     (bubble_ex),
        .flush_fd      (flush_fd),
        .freeze        (freeze),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .fwd_st        (fwd_st)
    );

    execute_stage i_execute (
        .clk            (clk),
        .rst            (rst),
        .op_a           (ex_op_a),
        .op_b           (ex_op_b),
        .store          (ex_store),
        .alu_op         (ex_alu_op),
        .dest           (ex_dest),
        .mem_read       (ex_mem_read),
        .mem_write      (ex_mem_write),
        .reg_write      (ex_reg_write),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .fwd_st         (fwd_st),
        .mem_alu_result (mem_result),
        .wb_data        (wb_data),
        .freeze         (freeze),
        .mem_result     (mem_result),
        .mem_store      (mem_store),
        .mem_dest       (mem_dest),
        .mem_mem_read   (mem_mem_read),
        .mem_mem_write  (mem_mem_write),
        .mem_reg_write  (mem_reg_write)
    );

    memory_stage i_memory (
        .clk        (clk),
        .rst        (rst),
        .alu_result (mem_result),
        .store_data (mem_store),
        .dest       (mem_dest),
        .mem_read   (mem_mem_read),
        .mem_write  (mem_mem_write),
        .reg_write  (mem_reg_write),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_dat_i   (wb_dat_i),
        .wb_sel     (wb_sel),
        .wb_ack     (wb_ack),
        .bus_busy   (bus_busy),
        .wb_en      (wb_en),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// File: test/cpu_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic                 wb_we,
    input logic [word_w-1:0]    wb_adr,
    input logic [word_w-1:0]    wb_dat_o,
    input logic [sel_w-1:0]     wb_sel,
    input logic                 wb_ack,
    input instr_u               fd_instr,
    input logic [reg_idx_w-1:0] id_rs,
    input logic [reg_idx_w-1:0] id_rt,
    input logic [reg_idx_w-1:0] ex_dest,
    input logic                 ex_reg_write,
    input logic [reg_idx_w-1:0] mem_dest,
    input logic                 mem_reg_write
);

    int         fail_count = 0;
    logic [7:0] since_rst;
    logic       is_branch;

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= '0;
        end else if (since_rst != 8'hff) begin
            since_rst <= since_rst + 8'd1;
        end
    end

    assign is_branch = (fd_instr.r.op == op_beq) || (fd_instr.r.op == op_bne);

    // first load or store is well past this window
    bus_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        (since_rst < 8'd8) |-> !wb_cyc && !wb_stb)
        else begin fail_count++; $error("bus active right after reset"); end

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_cyc)
        else begin fail_count++; $error("stb high without cyc"); end

    sel_all_ones: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_sel == '1)
        else begin fail_count++; $error("sel not all ones"); end

    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we) &&
                                $stable(wb_dat_o) && $stable(wb_sel))
        else begin fail_count++; $error("bus fields changed before ack"); end

    // branches compare raw register file values
    branch_operands_ready: assert property (@(posedge clk) disable iff (rst)
        is_branch |-> !(ex_reg_write && ex_dest != '0 &&
                        (ex_dest == id_rs || ex_dest == id_rt)) &&
                      !(mem_reg_write && mem_dest != '0 &&
                        (mem_dest == id_rs || mem_dest == id_rt)))
        else begin fail_count++; $error("branch reads a register still in flight"); end

endmodule

bind cpu_top cpu_asserts i_asserts (.*);

`default_nettype wire

// File: test/tb_cpu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int clk_period_ns  = 10;
    localparam int reset_cycles   = 16;
    localparam int timeout_cycles = 2000;
    localparam int settle_cycles  = 20;
    localparam int n_stores       = 7;

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [word_w-1:0] wb_adr;
    logic [word_w-1:0] wb_dat_o;
    logic [word_w-1:0] wb_dat_i;
    logic [sel_w-1:0]  wb_sel;
    logic              wb_ack;

    // slave memory and its wait state
    logic [word_w-1:0] mem [16];
    logic [1:0]        wait_left;
    logic              started;
    int                seed;

    // expected store sequence
    logic [word_w-1:0] exp_adr [16];
    logic [word_w-1:0] exp_dat [16];
    logic [3:0]        store_idx;
    logic [word_w-1:0] exp_adr_now;
    logic [word_w-1:0] exp_dat_now;
    int                cycle_count;

    cpu_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack)
    );

    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [word_w-1:0] got,
                                   input logic [word_w-1:0] expected);
        $display("CHECK FAILED time=%0t %s got %h expected %h", $time, name, got, expected);
        end_with_failure("store mismatch against the expected table");
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    initial begin
        seed      = 89675;
        rst       = 1'b1;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        started   = 1'b0;
        wait_left = '0;
        for (int k = 0; k < 16; k++) begin
            mem[k]     = $random(seed);
            exp_adr[k] = '0;
            exp_dat[k] = '0;
        end
        // hand-computed from program.hex
        exp_adr[0] = 32'h00;
        exp_dat[0] = 32'h0000_0001;
        exp_adr[1] = 32'h04;
        exp_dat[1] = 32'h0000_0025;
        exp_adr[2] = 32'h08;
        exp_dat[2] = 32'h0000_0020;
        exp_adr[3] = 32'h0c;
        exp_dat[3] = 32'hffff_ffde;
        // lw of word 8 plus 5
        exp_adr[4] = 32'h10;
        exp_dat[4] = mem[8] + 32'd5;
        exp_adr[5] = 32'h14;
        exp_dat[5] = 32'h0000_0028;
        exp_adr[6] = 32'h18;
        exp_dat[6] = 32'h0000_0023;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        wait (store_idx == 4'(n_stores));
        repeat (settle_cycles) @(negedge clk);
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            end_with_failure("bus assertions reported errors");
        end
    end

    // slave answers after 0 to 3 wait cycles
    always @(negedge clk) begin
        if (rst || wb_ack) begin
            wb_ack  = 1'b0;
            started = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!started) begin
                started   = 1'b1;
                wait_left = 2'($random(seed));
            end
            if (wait_left == 2'd0) begin
                wb_ack = 1'b1;
                if (wb_we) begin
                    mem[wb_adr[5:2]] = wb_dat_o;
                end else begin
                    wb_dat_i = mem[wb_adr[5:2]];
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            store_idx <= '0;
        end else if (wb_cyc && wb_stb && wb_we && wb_ack) begin
            store_idx <= store_idx + 4'd1;
        end
    end

    assign exp_adr_now = exp_adr[store_idx];
    assign exp_dat_now = exp_dat[store_idx];

    store_adr_ok: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && wb_we && wb_ack && store_idx < 4'(n_stores)) |-> wb_adr == exp_adr_now)
        else report_mismatch("wb_adr", $sampled(wb_adr), $sampled(exp_adr_now));

    store_dat_ok: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && wb_we && wb_ack && store_idx < 4'(n_stores)) |-> wb_dat_o == exp_dat_now)
        else report_mismatch("wb_dat_o", $sampled(wb_dat_o), $sampled(exp_dat_now));

    no_extra_store: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && wb_we && wb_ack) |-> store_idx < 4'(n_stores))
        else end_with_failure("a store appeared after the expected sequence ended");

    always @(negedge clk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            end_with_failure("a bus protocol assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            end_with_failure("timeout before all expected stores completed");
        end
    end

    initial begin
        cycle_count = 0;
    end

endmodule

`default_nettype wire

// File: test/program.hex
// one instruction word per line, word address 0 upwards
// chain of alu ops, stores, load-use, beq/bne/j
24010005
2422001e
00221821
00612023
00832824
00a13025
0026382a
ac070000
ac060004
ac050008
2408fffd
0101482a
00235023
012a5821
ac0b000c
8c0c0020
01816821
ac0d0010
10440002
ac010014
ac010018
14440002
ac030014
08000019
ac010018
ac040018
0800001a

// File: all.f
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
test/cpu_asserts.sv
test/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f all.f -o sim_cpu

# the instruction ROM loads program.hex from the working directory
(cd test && ../obj_dir/sim_cpu) > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
else
    exit 1
fi
